/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mrelbp_ci_r6_tb -f vlog.f

./obj_dir/Vmrelbp_ci_r6_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* tests/mrelbp_ci_r6_props.sv */
`timescale 1ns/1ps

module mrelbp_ci_r6_props (
    input logic clk,
    input logic rst,
    input logic classify_i,
    input logic ci_i,
    input logic ci_valid_i,
    input logic done_i,
    input logic progress_done_i
);
    int unsigned fail_cnt = 0;

    done_pulse: assert property (@(posedge clk) disable iff (rst) done_i |=> !done_i)
        else begin
            $error("done_o stayed high for more than one cycle");
            fail_cnt++;
        end

    // divider runs 16 steps plus the load cycle
    done_timing: assert property (@(posedge clk) disable iff (rst)
        done_i |-> $past(progress_done_i, 17))
        else begin
            $error("done_o did not follow progress_done_o by 17 cycles");
            fail_cnt++;
        end

    ci_in_classify: assert property (@(posedge clk) disable iff (rst)
        ci_valid_i |-> classify_i)
        else begin
            $error("ci_valid_o high outside the classification pass");
            fail_cnt++;
        end

    reset_quiet: assert property (@(posedge clk)
        rst |=> (!ci_i && !ci_valid_i && !done_i && !progress_done_i))
        else begin
            $error("outputs not low in the cycle after reset");
            fail_cnt++;
        end

endmodule

/* tests/mrelbp_ci_r6_tb.sv */
`timescale 1ns/1ps

module mrelbp_ci_r6_tb;
    import ci_geom_pkg::*;
    import ci_data_pkg::*;

    localparam int ROWS     = DEF_ROWS;
    localparam int COLS     = DEF_COLS;
    localparam int PIXELS   = ROWS * COLS;
    localparam int INTERIOR = (ROWS - 2 * WIN_RADIUS) * (COLS - 2 * WIN_RADIUS);
    localparam longint TIMEOUT_NS = 6 * 2 * (PIXELS + 20) * 40;
    localparam int unsigned SEED = 32'h8d17ce9d;

    logic clk;
    logic rst;
    logic start;
    logic pix_valid;
    pix_t smp [NUM_SAMPLES];
    logic ci;
    logic ci_valid;
    logic done;
    logic progress_done;

    pix_t frame [PIXELS][NUM_SAMPLES];
    bit   exp_q [$];
    bit   exp_bit;
    int   errors;
    int   ci_cnt;
    int   done_cnt;
    int   tests_passed;
    int   tests_failed;

    mrelbp_ci_r6 #(
        .ROWS(ROWS),
        .COLS(COLS)
    ) mrelbp_ci_r6_inst (
        .clk             (clk),
        .rst             (rst),
        .start_i         (start),
        .pix_valid_i     (pix_valid),
        .sample_1_i      (smp[0]),
        .sample_2_i      (smp[1]),
        .sample_3_i      (smp[2]),
        .sample_4_i      (smp[3]),
        .sample_5_i      (smp[4]),
        .sample_6_i      (smp[5]),
        .sample_7_i      (smp[6]),
        .sample_8_i      (smp[7]),
        .sample_9_i      (smp[8]),
        .sample_10_i     (smp[9]),
        .sample_11_i     (smp[10]),
        .sample_12_i     (smp[11]),
        .sample_13_i     (smp[12]),
        .ci_o            (ci),
        .ci_valid_o      (ci_valid),
        .done_o          (done),
        .progress_done_o (progress_done)
    );

    bind mrelbp_ci_r6 mrelbp_ci_r6_props props_inst (
        .clk             (clk),
        .rst             (rst),
        .classify_i      (classify),
        .ci_i            (ci_o),
        .ci_valid_i      (ci_valid_o),
        .done_i          (done_o),
        .progress_done_i (progress_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int fail_total();
        return errors + int'(mrelbp_ci_r6_inst.props_inst.fail_cnt);
    endfunction

    function automatic int local_of(int p);
        int sum;
        sum = 0;
        for (int s = 0; s < NUM_SAMPLES; s++) begin
            sum += int'(frame[p][s]);
        end
        return sum;
    endfunction

    function automatic bit is_interior(int p);
        int r;
        int c;
        r = p / COLS;
        c = p % COLS;
        return (r >= WIN_RADIUS) && (r < ROWS - WIN_RADIUS) &&
               (c >= WIN_RADIUS) && (c < COLS - WIN_RADIUS);
    endfunction

    // mean over interior positions, ties high only when exact
    task automatic build_expected();
        int total;
        int mu;
        int r;
        total = 0;
        for (int p = 0; p < PIXELS; p++) begin
            if (is_interior(p)) total += local_of(p);
        end
        mu = total / INTERIOR;
        r  = total % INTERIOR;
        exp_q.delete();
        for (int p = 0; p < PIXELS; p++) begin
            if (is_interior(p)) begin
                exp_q.push_back((local_of(p) > mu) || ((local_of(p) == mu) && (r == 0)));
            end
        end
    endtask

    task automatic fill_frame(input int mode);
        int v;
        int bright;
        v      = $urandom_range(0, 255);
        bright = (WIN_RADIUS + $urandom_range(0, ROWS - 13)) * COLS +
                 WIN_RADIUS + $urandom_range(0, COLS - 13);
        for (int p = 0; p < PIXELS; p++) begin
            for (int s = 0; s < NUM_SAMPLES; s++) begin
                case (mode)
                    0:       frame[p][s] = pix_t'($urandom_range(0, 255));
                    1:       frame[p][s] = pix_t'(v);
                    default: frame[p][s] = (p == bright) ? 8'd255 : 8'd0;
                endcase
            end
        end
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic send_beats(input int count, input bit gaps);
        for (int p = 0; p < count; p++) begin
            if (gaps) begin
                repeat ($urandom_range(0, 1)) begin
                    @(negedge clk);
                    pix_valid = 1'b0;
                end
            end
            @(negedge clk);
            pix_valid = 1'b1;
            smp       = frame[p];
        end
        @(negedge clk);
        pix_valid = 1'b0;
    endtask

    task automatic report_test(input string name, input int err_before);
        if (fail_total() == err_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, fail_total() - err_before);
        end
    endtask

    task automatic run_frame(input string name, input bit gaps);
        int err_before;
        int exp_n;
        err_before = fail_total();
        build_expected();
        exp_n = exp_q.size();
        pulse_start();
        send_beats(PIXELS, gaps);
        // one clock after the last learning beat
        assert (progress_done) else begin
            errors++;
            $display("Error: time %0t ns, progress_done_o expected 1, got %0b",
                     $time, progress_done);
        end
        while (!done) @(negedge clk);
        @(negedge clk); // decode moves to classify on this edge
        ci_cnt = 0;
        send_beats(PIXELS, gaps);
        repeat (2) @(negedge clk);
        assert (ci_cnt == exp_n) else begin
            errors++;
            $display("Error: time %0t ns, ci_valid_o pulse count expected %0d, got %0d",
                     $time, exp_n, ci_cnt);
        end
        report_test(name, err_before);
    endtask

    // compare each result against the model queue
    always @(negedge clk) begin
        if (done) begin
            done_cnt++;
        end
        if (ci_valid) begin
            ci_cnt++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("ci_valid_o pulsed at %0t ns with no result expected", $time);
            end
            if (exp_q.size() != 0) begin
                exp_bit = exp_q.pop_front();
                assert (ci == exp_bit) else begin
                    errors++;
                    $display("Error: time %0t ns, ci_o expected %0b, got %0b",
                             $time, exp_bit, ci);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int err_before;
        int done_before;
        void'($urandom(SEED));
        rst          = 1'b1;
        start        = 1'b0;
        pix_valid    = 1'b0;
        smp          = '{default: '0};
        errors       = 0;
        ci_cnt       = 0;
        done_cnt     = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        fill_frame(0);
        run_frame("random frame", 1'b0);
        run_frame("gapped stream", 1'b1); // same data as above
        fill_frame(1);
        run_frame("uniform frame", 1'b0);
        fill_frame(2);
        run_frame("single bright position", 1'b0);

        err_before = fail_total();
        fill_frame(0);
        pulse_start();
        send_beats(PIXELS / 2, 1'b0);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        done_before = done_cnt;
        send_beats(PIXELS, 1'b0); // no start, an idle design ignores these
        repeat (20) @(negedge clk);
        assert (done_cnt == done_before) else begin
            errors++;
            $display("done_o pulsed after reset without a start pulse at %0t ns", $time);
        end
        report_test("reset during learning", err_before);
        run_frame("random frame after reset", 1'b0);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && fail_total() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog/ci_data_pkg.sv */
package ci_data_pkg;

    localparam int PIX_W   = 8;
    localparam int LOCAL_W = 12; // 13 * 255 fits
    localparam int ACC_W   = 16; // 9 interior positions at full scale
    localparam int POS_W   = 5;  // dimensions up to 31

    typedef logic [PIX_W-1:0]   pix_t;
    typedef logic [LOCAL_W-1:0] local_t;
    typedef logic [ACC_W-1:0]   acc_t;

    // mu can never exceed the largest local value
    typedef logic [LOCAL_W-1:0] mean_t;
    typedef logic [LOCAL_W-1:0] rem_t;

    typedef logic [POS_W-1:0]   pos_t;

endpackage

/* verilog/ci_geom_pkg.sv */
package ci_geom_pkg;

    // default frame size
    localparam int DEF_ROWS = 15;
    localparam int DEF_COLS = 15;

    // MRELBP radius 6 window, interior starts this far from every edge
    localparam int WIN_RADIUS = 6;

    localparam int NUM_SAMPLES = 13; // smoothing samples per beat

endpackage

/* verilog/mrelbp_ci_r6.sv */
`timescale 1ns/1ps

module mrelbp_ci_r6 #(
    parameter int ROWS = ci_geom_pkg::DEF_ROWS,
    parameter int COLS = ci_geom_pkg::DEF_COLS
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_i,
    input  logic              pix_valid_i,
    input  ci_data_pkg::pix_t sample_1_i,
    input  ci_data_pkg::pix_t sample_2_i,
    input  ci_data_pkg::pix_t sample_3_i,
    input  ci_data_pkg::pix_t sample_4_i,
    input  ci_data_pkg::pix_t sample_5_i,
    input  ci_data_pkg::pix_t sample_6_i,
    input  ci_data_pkg::pix_t sample_7_i,
    input  ci_data_pkg::pix_t sample_8_i,
    input  ci_data_pkg::pix_t sample_9_i,
    input  ci_data_pkg::pix_t sample_10_i,
    input  ci_data_pkg::pix_t sample_11_i,
    input  ci_data_pkg::pix_t sample_12_i,
    input  ci_data_pkg::pix_t sample_13_i,
    output logic              ci_o,
    output logic              ci_valid_o,
    output logic              done_o,
    output logic              progress_done_o
);
    import ci_data_pkg::*;

    logic   pos_interior;
    logic   learn;
    logic   classify;
    logic   learn_end;
    logic   local_valid;
    local_t local_val;
    acc_t   acc;
    mean_t  mu;
    rem_t   rem;

    // decode
    r6_scan_decode #(
        .ROWS(ROWS),
        .COLS(COLS)
    ) r6_scan_decode_inst (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start_i),
        .pix_valid_i    (pix_valid_i),
        .div_done_i     (done_o),
        .pos_interior_o (pos_interior),
        .learn_o        (learn),
        .classify_o     (classify),
        .learn_end_o    (learn_end)
    );

    // execute
    r6_window_sum r6_window_sum_inst (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start_i),
        .pix_valid_i    (pix_valid_i),
        .pos_interior_i (pos_interior),
        .learn_i        (learn),
        .sample_1_i     (sample_1_i),
        .sample_2_i     (sample_2_i),
        .sample_3_i     (sample_3_i),
        .sample_4_i     (sample_4_i),
        .sample_5_i     (sample_5_i),
        .sample_6_i     (sample_6_i),
        .sample_7_i     (sample_7_i),
        .sample_8_i     (sample_8_i),
        .sample_9_i     (sample_9_i),
        .sample_10_i    (sample_10_i),
        .sample_11_i    (sample_11_i),
        .sample_12_i    (sample_12_i),
        .sample_13_i    (sample_13_i),
        .local_o        (local_val),
        .local_valid_o  (local_valid),
        .acc_o          (acc)
    );

    r6_mean_div #(
        .ROWS(ROWS),
        .COLS(COLS)
    ) r6_mean_div_inst (
        .clk             (clk),
        .rst             (rst),
        .start_i         (start_i),
        .learn_end_i     (learn_end),
        .acc_i           (acc),
        .mu_o            (mu),
        .rem_o           (rem),
        .done_o          (done_o),
        .progress_done_o (progress_done_o)
    );

    // result
    r6_ci_result r6_ci_result_inst (
        .clk           (clk),
        .rst           (rst),
        .classify_i    (classify),
        .local_valid_i (local_valid),
        .local_i       (local_val),
        .mu_i          (mu),
        .rem_i         (rem),
        .ci_o          (ci_o),
        .ci_valid_o    (ci_valid_o)
    );

endmodule

/* verilog/r6_ci_result.sv */
`timescale 1ns/1ps

module r6_ci_result (
    input  logic               clk,
    input  logic               rst,
    input  logic               classify_i,
    input  logic               local_valid_i,
    input  ci_data_pkg::local_t local_i,
    input  ci_data_pkg::mean_t  mu_i,
    input  ci_data_pkg::rem_t   rem_i,
    output logic               ci_o,
    output logic               ci_valid_o
);
    logic take;
    logic above;

    assign take = classify_i && local_valid_i;

    // ties count as above only for an exact mean
    assign above = (local_i > mu_i) || ((local_i == mu_i) && (rem_i == '0));

    always_ff @(posedge clk) begin
        if (rst) begin
            ci_o       <= 1'b0;
            ci_valid_o <= 1'b0;
        end else begin
            ci_valid_o <= take;
            ci_o       <= take && above; // low between results
        end
    end

endmodule

/* verilog/r6_mean_div.sv */
`timescale 1ns/1ps

module r6_mean_div #(
    parameter int ROWS = 15,
    parameter int COLS = 15
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start_i,
    input  logic                learn_end_i,
    input  ci_data_pkg::acc_t   acc_i,
    output ci_data_pkg::mean_t  mu_o,
    output ci_data_pkg::rem_t   rem_o,
    output logic                done_o,
    output logic                progress_done_o
);
    import ci_geom_pkg::*;
    import ci_data_pkg::*;

    localparam int INTERIOR = (ROWS - 2 * WIN_RADIUS) * (COLS - 2 * WIN_RADIUS);
    localparam logic [ACC_W:0] DIVISOR = (ACC_W + 1)'(INTERIOR);
    localparam int CNT_W = $clog2(ACC_W);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(ACC_W - 1);

    logic             armed;
    logic             busy;
    logic             launch;
    logic [CNT_W-1:0] step_cnt;
    acc_t             quo;
    acc_t             part;   // partial remainder
    logic [ACC_W:0]   trial;
    logic             fits;
    acc_t             part_next;
    acc_t             quo_next;

    assign launch = progress_done_o && armed && !busy;

    // one restoring step
    assign trial     = {part, quo[ACC_W-1]};
    assign fits      = (trial >= DIVISOR);
    assign part_next = fits ? acc_t'(trial - DIVISOR) : acc_t'(trial);
    assign quo_next  = {quo[ACC_W-2:0], fits};

    always_ff @(posedge clk) begin
        if (rst) begin
            progress_done_o <= 1'b0;
            armed           <= 1'b0;
            busy            <= 1'b0;
            step_cnt        <= '0;
            done_o          <= 1'b0;
        end else begin
            progress_done_o <= learn_end_i;
            done_o          <= 1'b0;
            if (start_i) begin
                armed <= 1'b1;
            end
            if (launch) begin
                busy     <= 1'b1;
                armed    <= 1'b0;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == LAST_STEP) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            quo  <= acc_i; // total is complete one cycle after the last beat
            part <= '0;
        end else if (busy) begin
            quo  <= quo_next;
            part <= part_next;
            if (step_cnt == LAST_STEP) begin
                mu_o  <= mean_t'(quo_next);
                rem_o <= rem_t'(part_next);
            end
        end
    end

endmodule

/* verilog/r6_scan_decode.sv */
`timescale 1ns/1ps

module r6_scan_decode #(
    parameter int ROWS = 15,
    parameter int COLS = 15
) (
    input  logic clk,
    input  logic rst,
    input  logic start_i,
    input  logic pix_valid_i,
    input  logic div_done_i,
    output logic pos_interior_o,
    output logic learn_o,
    output logic classify_o,
    output logic learn_end_o
);
    import ci_geom_pkg::*;
    import ci_data_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LEARN,
        ST_WAIT,     // divider running
        ST_CLASSIFY
    } pass_t;

    localparam pos_t LAST_ROW = pos_t'(ROWS - 1);
    localparam pos_t LAST_COL = pos_t'(COLS - 1);
    localparam pos_t EDGE_LO  = pos_t'(WIN_RADIUS);
    localparam pos_t ROW_HI   = pos_t'(ROWS - 1 - WIN_RADIUS);
    localparam pos_t COL_HI   = pos_t'(COLS - 1 - WIN_RADIUS);

    pass_t state;
    pos_t  row;
    pos_t  col;
    logic  active;
    logic  step;
    logic  last_beat;

    assign active    = (state == ST_LEARN) || (state == ST_CLASSIFY);
    assign step      = active && pix_valid_i;
    assign last_beat = (row == LAST_ROW) && (col == LAST_COL);

    // raster position of the current beat
    always_ff @(posedge clk) begin
        if (rst || start_i) begin
            row <= '0;
            col <= '0;
        end else if (step) begin
            if (last_beat) begin
                row <= '0;
                col <= '0;
            end else if (col == LAST_COL) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else if (start_i) begin
            state <= ST_LEARN; // restart from any pass
        end else begin
            case (state)
                ST_LEARN:    if (step && last_beat) state <= ST_WAIT;
                ST_WAIT:     if (div_done_i) state <= ST_CLASSIFY;
                ST_CLASSIFY: if (step && last_beat) state <= ST_IDLE;
                default:     state <= state;
            endcase
        end
    end

    assign learn_o     = (state == ST_LEARN);
    assign classify_o  = (state == ST_CLASSIFY);
    assign learn_end_o = learn_o && step && last_beat;

    assign pos_interior_o = active &&
                            (row >= EDGE_LO) && (row <= ROW_HI) &&
                            (col >= EDGE_LO) && (col <= COL_HI);

endmodule

/* verilog/r6_window_sum.sv */
`timescale 1ns/1ps

module r6_window_sum (
    input  logic                clk,
    input  logic                rst,
    input  logic                start_i,
    input  logic                pix_valid_i,
    input  logic                pos_interior_i,
    input  logic                learn_i,
    input  ci_data_pkg::pix_t   sample_1_i,
    input  ci_data_pkg::pix_t   sample_2_i,
    input  ci_data_pkg::pix_t   sample_3_i,
    input  ci_data_pkg::pix_t   sample_4_i,
    input  ci_data_pkg::pix_t   sample_5_i,
    input  ci_data_pkg::pix_t   sample_6_i,
    input  ci_data_pkg::pix_t   sample_7_i,
    input  ci_data_pkg::pix_t   sample_8_i,
    input  ci_data_pkg::pix_t   sample_9_i,
    input  ci_data_pkg::pix_t   sample_10_i,
    input  ci_data_pkg::pix_t   sample_11_i,
    input  ci_data_pkg::pix_t   sample_12_i,
    input  ci_data_pkg::pix_t   sample_13_i,
    output ci_data_pkg::local_t local_o,
    output logic                local_valid_o,
    output ci_data_pkg::acc_t   acc_o
);
    import ci_geom_pkg::*;
    import ci_data_pkg::*;

    pix_t   samples [NUM_SAMPLES];
    local_t sum_c;
    logic   take;

    assign samples = '{sample_1_i, sample_2_i, sample_3_i, sample_4_i,
                       sample_5_i, sample_6_i, sample_7_i, sample_8_i,
                       sample_9_i, sample_10_i, sample_11_i, sample_12_i,
                       sample_13_i};

    always_comb begin
        sum_c = '0;
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            sum_c = sum_c + local_t'(samples[i]);
        end
    end

    assign take = pix_valid_i && pos_interior_i;

    always_ff @(posedge clk) begin
        if (take) begin
            local_o <= sum_c;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            local_valid_o <= 1'b0;
            acc_o         <= '0;
        end else begin
            local_valid_o <= take;
            if (start_i) begin
                acc_o <= '0;
            end else if (take && learn_i) begin
                acc_o <= acc_o + acc_t'(sum_c); // same edge as local_o
            end
        end
    end

endmodule

/* vlog.f */
verilog/ci_geom_pkg.sv
verilog/ci_data_pkg.sv
verilog/r6_scan_decode.sv
verilog/r6_window_sum.sv
verilog/r6_mean_div.sv
verilog/r6_ci_result.sv
verilog/mrelbp_ci_r6.sv
tests/mrelbp_ci_r6_props.sv
tests/mrelbp_ci_r6_tb.sv
